//--- rtl/zports_defines.svh
////////////////////////////////////////////////////////////////////////////
// z80 i/o port block defines
// port addresses, register bit positions and reset values
////////////////////////////////////////////////////////////////////////////

`ifndef ZPORTS_DEFINES_SVH
`define ZPORTS_DEFINES_SVH

// low address bytes of the decoded ports
`define PORT_FE       8'hFE     // border, beeper, keyboard
`define PORT_F6       8'hF6     // alias of #FE
`define PORT_FD       8'hFD     // #7FFD paging, #FFFD/#BFFD ay
`define PORT_F7       8'hF7     // #EFF7 pentagon-1m
`define PORT_KJOY     8'h1F     // kempston joystick
`define PORT_KMOUSE   8'hDF     // kempston mouse
`define PORT_CFG      8'hBF     // shadow, rom write, nmi
`define PORT_NMICLR   8'hBE     // write ends nmi

// #7FFD bits
`define P7FFD_LOCK_BIT      5   // 48k lock
`define P7FFD_ROM_BIT       4

// #EFF7 bits
`define PEFF7_BLOCK1M_BIT   2   // 1 = 1m paging off
`define PEFF7_RAM0_BIT      3   // ram page 0 in rom area

// #BF bits
`define CFG_SHADOW_BIT      0
`define CFG_ROMRW_BIT       1
`define CFG_NMI_BIT         3

// reset values
`define P7FFD_RST     8'h00
`define PEFF7_RST     8'h00
`define BORDER_RST    4'h0

// unmapped read
`define FLOAT_BYTE    8'hFF

`endif

//--- rtl/zports_pkg.sv
////////////////////////////////////////////////////////////////////////////
// z80 i/o port block types
// widths of address, data, page number and border colour
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package zports_pkg;

	// low address byte, selects the port
	typedef logic [7:0] port_addr_t;

	// data byte on the z80 bus
	typedef logic [7:0] io_byte_t;

	// pentagon-1m ram page, #7FFD 7..5 and 2..0
	typedef logic [5:0] mem_page_t;

	// bright bit + grb
	typedef logic [3:0] border_t;

endpackage

`default_nettype wire

//--- rtl/zbus_if.sv
////////////////////////////////////////////////////////////////////////////
// qualified z80 i/o cycle
// one-cycle strobes plus address halves and data byte
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface zbus_if;

	import zports_pkg::*;

	logic       port_wr;    // one zclk pulse per i/o write
	logic       port_rd;    // one zclk pulse per i/o read
	port_addr_t loa;        // a7..a0
	io_byte_t   a_hi;       // a15..a8
	io_byte_t   din;        // z80 data bus

	// strobe generator side
	modport source (
		output port_wr,
		output port_rd,
		output loa,
		output a_hi,
		output din
	);

	// register and decode blocks
	modport sink (
		input port_wr,
		input port_rd,
		input loa,
		input a_hi,
		input din
	);

endinterface

`default_nettype wire

//--- rtl/io_strobe.sv
////////////////////////////////////////////////////////////////////////////
// i/o cycle detector
// turns iorq_n with rd_n/wr_n into single zclk read and write pulses
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "zports_defines.svh"

module io_strobe (
	input  logic                 zclk,
	input  logic                 rst_n,
	input  logic                 iorq_n,
	input  logic                 rd_n,
	input  logic                 wr_n,
	input  logic [15:0]          a,
	input  zports_pkg::io_byte_t din,
	zbus_if.source               bus
);

	import zports_pkg::*;

	logic iowr_now;     // write level, this cycle
	logic iord_now;
	logic iowr_lvl;     // write level, previous edge
	logic iord_lvl;
	logic port_wr_q;
	logic port_rd_q;

	assign iowr_now = ~(iorq_n | wr_n);
	assign iord_now = ~(iorq_n | rd_n);

	// pulse on the first edge a level is seen, then wait for it to drop
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			iowr_lvl  <= 1'b0;
			iord_lvl  <= 1'b0;
			port_wr_q <= 1'b0;
			port_rd_q <= 1'b0;
		end
		else
		begin
			iowr_lvl  <= iowr_now;
			iord_lvl  <= iord_now;
			port_wr_q <= iowr_now & ~iowr_lvl;  // rising level only
			port_rd_q <= iord_now & ~iord_lvl;
		end
	end

	assign bus.port_wr = port_wr_q;
	assign bus.port_rd = port_rd_q;

	// address and data go straight through
	assign bus.loa  = port_addr_t'(a[7:0]);
	assign bus.a_hi = io_byte_t'(a[15:8]);
	assign bus.din  = din;

	////////////////////////////////////////////////////////////////////////////
	// checks

	// a broken bus cycle with both rd_n and wr_n low must not reach the ports
	a_rd_wr_excl: assert property (@(posedge zclk) disable iff (!rst_n)
		!(port_wr_q && port_rd_q));

	// however long wr_n stays low, only one write pulse
	a_wr_single: assert property (@(posedge zclk) disable iff (!rst_n)
		port_wr_q |=> !port_wr_q);

endmodule

`default_nettype wire

//--- rtl/port_decode.sv
////////////////////////////////////////////////////////////////////////////
// port decoder
// port hit flags, read-back mux and ay chip select
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "zports_defines.svh"

module port_decode (
	zbus_if.sink                 bus,
	input  logic                 iorq_n,
	input  logic                 rd_n,
	input  logic                 wr_n,
	input  logic                 shadow,
	input  zports_pkg::io_byte_t cfg_readback,
	input  logic [4:0]           keys_in,
	input  logic [4:0]           kj_in,
	input  zports_pkg::io_byte_t mus_in,
	input  logic                 tape_read,
	output logic                 porthit,
	output logic                 external_port,
	output logic                 dataout,
	output zports_pkg::io_byte_t dout,
	output logic                 ay_bc1,
	output logic                 ay_bdir
);

	import zports_pkg::*;

	logic pre_bc1;
	logic pre_bdir;

	// internal ports, drives iorq1_n/iorq2_n style gating outside
	always_comb
	begin
		case (bus.loa)
			`PORT_FE, `PORT_F6, `PORT_FD,
			`PORT_KMOUSE, `PORT_CFG, `PORT_NMICLR:
				porthit = 1'b1;
			`PORT_KJOY, `PORT_F7:
				porthit = ~shadow;   // hidden in shadow mode
			default:
				porthit = 1'b0;
		endcase
	end

	// ay sits on the external bus, #BFFD/#FFFD
	assign external_port = (bus.loa == `PORT_FD) & bus.a_hi[7];

	assign dataout = porthit & ~iorq_n & ~rd_n & ~external_port;

	////////////////////////////////////////////////////////////////////////////
	// read-back

	always_comb
	begin
		case (bus.loa)
			`PORT_FE, `PORT_F6:
				dout = {1'b1, tape_read, 1'b0, keys_in};
			`PORT_KJOY:
				dout = shadow ? io_byte_t'(`FLOAT_BYTE) : {3'b000, kj_in};
			`PORT_KMOUSE:
				dout = mus_in;
			`PORT_CFG:
				dout = cfg_readback;
			default:
				dout = `FLOAT_BYTE;  // #F7 and the rest float
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// ay control

	always_comb
	begin
		pre_bc1  = 1'b0;
		pre_bdir = 1'b0;
		if (bus.loa == `PORT_FD)
		begin
			if (bus.a_hi[7:6] == 2'b11)         // #FFFD reg select / read
			begin
				pre_bc1  = 1'b1;
				pre_bdir = 1'b1;
			end
			else if (bus.a_hi[7:6] == 2'b10)    // #BFFD data write
			begin
				pre_bdir = 1'b1;
			end
		end
	end

	assign ay_bc1  = pre_bc1 & ~iorq_n & (~rd_n | ~wr_n);
	assign ay_bdir = pre_bdir & ~iorq_n & ~wr_n;

endmodule

`default_nettype wire

//--- rtl/mem_paging.sv
////////////////////////////////////////////////////////////////////////////
// memory paging ports
// #7FFD 128k paging with 48k lock, #EFF7 pentagon-1m control
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "zports_defines.svh"

module mem_paging (
	input  logic                  zclk,
	input  logic                  rst_n,
	zbus_if.sink                  bus,
	input  logic                  shadow,
	output zports_pkg::io_byte_t  p7ffd,
	output zports_pkg::io_byte_t  peff7,
	output zports_pkg::mem_page_t pent1m_page,
	output logic                  pent1m_rom,
	output logic                  pent1m_1m_on,
	output logic                  pent1m_ram0_0
);

	import zports_pkg::*;

	io_byte_t p7ffd_raw;
	io_byte_t peff7_raw;
	logic     block1m;      // 1m paging off
	logic     lock_7ffd;
	logic     p7ffd_wr;
	logic     peff7_wr;

	assign block1m   = peff7_raw[`PEFF7_BLOCK1M_BIT];
	assign lock_7ffd = p7ffd_raw[`P7FFD_LOCK_BIT] & block1m;  // 48k lock only in 128k mode

	// #7FFD: a15=0
	assign p7ffd_wr = bus.port_wr & (bus.loa == `PORT_FD) & ~bus.a_hi[7] & ~lock_7ffd;
	// #EFF7: a8=1, a12=0, not in shadow mode
	assign peff7_wr = bus.port_wr & (bus.loa == `PORT_F7) & bus.a_hi[0] & ~bus.a_hi[4]
		& ~shadow;

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			p7ffd_raw <= `P7FFD_RST;
		else if (p7ffd_wr)
			p7ffd_raw <= bus.din;   // 2..0 page, 3 screen, 4 rom, 5 lock, 7..6 hi page
	end

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			peff7_raw <= `PEFF7_RST;
		else if (peff7_wr)
			peff7_raw <= bus.din;
	end

	// visible copies, 1m bits masked in 128k mode
	assign p7ffd = {(block1m ? 3'b000 : p7ffd_raw[7:5]), p7ffd_raw[4:0]};
	assign peff7 = block1m ? {peff7_raw[7], 1'b0, peff7_raw[5:4], 3'b000, peff7_raw[0]}
		: peff7_raw;

	assign pent1m_page   = {p7ffd_raw[7:5], p7ffd_raw[2:0]};
	assign pent1m_rom    = p7ffd_raw[`P7FFD_ROM_BIT];
	assign pent1m_1m_on  = ~block1m;
	assign pent1m_ram0_0 = peff7_raw[`PEFF7_RAM0_BIT];

	// locked #7FFD holds until #EFF7 reopens it
	a_lock_hold: assert property (@(posedge zclk) disable iff (!rst_n)
		lock_7ffd |=> $stable(p7ffd_raw));

endmodule

`default_nettype wire

//--- rtl/sys_config.sv
////////////////////////////////////////////////////////////////////////////
// system config ports
// #BF config register, border, beeper and nmi-clear strobes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "zports_defines.svh"

module sys_config (
	input  logic                 zclk,
	input  logic                 rst_n,
	zbus_if.sink                 bus,
	input  logic                 dos,
	output logic                 shadow,
	output zports_pkg::io_byte_t cfg_readback,
	output logic                 romrw_en,
	output logic                 set_nmi,
	output zports_pkg::border_t  border,
	output logic                 beeper_wr,
	output logic                 clr_nmi
);

	import zports_pkg::*;

	logic shadow_en;
	logic cfg_wr;
	logic border_wr;

	assign cfg_wr    = bus.port_wr & (bus.loa == `PORT_CFG);
	assign border_wr = bus.port_wr & ((bus.loa == `PORT_FE) | (bus.loa == `PORT_F6));

	// #BF write
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			shadow_en <= 1'b0;
			romrw_en  <= 1'b0;
			set_nmi   <= 1'b0;
		end
		else if (cfg_wr)
		begin
			shadow_en <= bus.din[`CFG_SHADOW_BIT];
			romrw_en  <= bus.din[`CFG_ROMRW_BIT];
			set_nmi   <= bus.din[`CFG_NMI_BIT];
		end
	end

	assign shadow = dos | shadow_en;    // shadow ports follow trdos too

	always_comb
	begin
		cfg_readback                  = '0;
		cfg_readback[`CFG_SHADOW_BIT] = shadow_en;
		cfg_readback[`CFG_ROMRW_BIT]  = romrw_en;
		cfg_readback[`CFG_NMI_BIT]    = set_nmi;
	end

	// border, bright from inverted a3
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			border <= `BORDER_RST;
		else if (border_wr)
			border <= {~bus.loa[3], bus.din[2:0]};
	end

	// strobes share the port_wr cycle
	assign beeper_wr = bus.port_wr & (bus.loa == `PORT_FE);    // not on #F6
	assign clr_nmi   = bus.port_wr & (bus.loa == `PORT_NMICLR);

endmodule

`default_nettype wire

//--- rtl/zports_top.sv
////////////////////////////////////////////////////////////////////////////
// z80 i/o port block, zclk domain
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "zports_defines.svh"

module zports_top (
	input  logic                  zclk,
	input  logic                  rst_n,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic [15:0]           a,
	input  zports_pkg::io_byte_t  din,
	input  logic                  dos,
	input  logic [4:0]            keys_in,
	input  logic [4:0]            kj_in,
	input  zports_pkg::io_byte_t  mus_in,
	input  logic                  tape_read,
	output logic                  porthit,
	output logic                  external_port,
	output logic                  dataout,
	output zports_pkg::io_byte_t  dout,
	output logic                  ay_bc1,
	output logic                  ay_bdir,
	output zports_pkg::io_byte_t  p7ffd,
	output zports_pkg::io_byte_t  peff7,
	output zports_pkg::mem_page_t pent1m_page,
	output logic                  pent1m_rom,
	output logic                  pent1m_1m_on,
	output logic                  pent1m_ram0_0,
	output logic                  romrw_en,
	output logic                  set_nmi,
	output zports_pkg::border_t   border,
	output logic                  beeper_wr,
	output logic                  clr_nmi
);

	import zports_pkg::*;

	logic     shadow;
	io_byte_t cfg_readback;

	zbus_if bus ();

	io_strobe u_strobe (
		.zclk(zclk), .rst_n(rst_n),
		.iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
		.a(a), .din(din), .bus(bus)
	);

	port_decode u_decode (
		.bus(bus), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
		.shadow(shadow), .cfg_readback(cfg_readback),
		.keys_in(keys_in), .kj_in(kj_in), .mus_in(mus_in), .tape_read(tape_read),
		.porthit(porthit), .external_port(external_port), .dataout(dataout),
		.dout(dout), .ay_bc1(ay_bc1), .ay_bdir(ay_bdir)
	);

	mem_paging u_paging (
		.zclk(zclk), .rst_n(rst_n), .bus(bus), .shadow(shadow),
		.p7ffd(p7ffd), .peff7(peff7), .pent1m_page(pent1m_page),
		.pent1m_rom(pent1m_rom), .pent1m_1m_on(pent1m_1m_on),
		.pent1m_ram0_0(pent1m_ram0_0)
	);

	sys_config u_config (
		.zclk(zclk), .rst_n(rst_n), .bus(bus), .dos(dos),
		.shadow(shadow), .cfg_readback(cfg_readback),
		.romrw_en(romrw_en), .set_nmi(set_nmi), .border(border),
		.beeper_wr(beeper_wr), .clr_nmi(clr_nmi)
	);

endmodule

`default_nettype wire

//--- verification/zports_tb.sv
////////////////////////////////////////////////////////////////////////////
// z80 i/o port block testbench
// table of bus cycles with expected values, applied in a loop
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "zports_defines.svh"

module zports_tb;

	localparam int OP_WR  = 0;
	localparam int OP_RD  = 1;
	localparam int OP_CHK = 2;      // no bus cycle, look only
	localparam int TIMEOUT_CYCLES = 4000;

	logic        zclk;
	logic        rst_n;
	logic        iorq_n, rd_n, wr_n;
	logic [15:0] a;
	logic [7:0]  din;
	logic        dos;
	logic [4:0]  keys_in, kj_in;
	logic [7:0]  mus_in;
	logic        tape_read;
	logic        porthit, external_port, dataout, ay_bc1, ay_bdir;
	logic [7:0]  dout, p7ffd, peff7;
	logic [5:0]  pent1m_page;
	logic        pent1m_rom, pent1m_1m_on, pent1m_ram0_0;
	logic        romrw_en, set_nmi, beeper_wr, clr_nmi;
	logic [3:0]  border;

	// stimulus table, one queue per column
	int          op_q[$];
	logic [15:0] addr_q[$];
	logic [7:0]  data_q[$];
	logic [7:0]  exp_q[$];
	string       sig_q[$];

	logic [4:0]  keys_v, kj_v;      // random pin levels
	logic [7:0]  mus_v;
	logic        tape_v;
	int          beep_cnt = 0;      // strobe counters
	int          clr_cnt = 0;
	int          beep_base = 0;
	int          clr_base = 0;

	zports_top uut (
		.zclk(zclk), .rst_n(rst_n), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
		.a(a), .din(din), .dos(dos), .keys_in(keys_in), .kj_in(kj_in),
		.mus_in(mus_in), .tape_read(tape_read), .porthit(porthit),
		.external_port(external_port), .dataout(dataout), .dout(dout),
		.ay_bc1(ay_bc1), .ay_bdir(ay_bdir), .p7ffd(p7ffd), .peff7(peff7),
		.pent1m_page(pent1m_page), .pent1m_rom(pent1m_rom),
		.pent1m_1m_on(pent1m_1m_on), .pent1m_ram0_0(pent1m_ram0_0),
		.romrw_en(romrw_en), .set_nmi(set_nmi), .border(border),
		.beeper_wr(beeper_wr), .clr_nmi(clr_nmi)
	);

	initial zclk = 1'b0;
	always #50 zclk = ~zclk;            // 100 ns period

	// count strobe cycles, each entry looks at its own delta
	always @(posedge zclk)
	begin
		if (beeper_wr)
			beep_cnt <= beep_cnt + 1;
		if (clr_nmi)
			clr_cnt <= clr_cnt + 1;
	end

	task automatic wait_clocks(input int n);
		int i;
		for (i = 0; i < n; i++)
		begin
			@(posedge zclk);
		end
	endtask

	task automatic compare(input string sig, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			$display("[ERROR] %s: got 0x%02h, expected 0x%02h", sig, got, exp);
			$display("Some tests failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// value of a named output, widened to a byte
	function automatic logic [7:0] observed(input string sig);
		case (sig)
			"porthit":       return {7'b0, porthit};
			"external_port": return {7'b0, external_port};
			"dataout":       return {7'b0, dataout};
			"dout":          return dout;
			"ay_bc1":        return {7'b0, ay_bc1};
			"ay_bdir":       return {7'b0, ay_bdir};
			"p7ffd":         return p7ffd;
			"peff7":         return peff7;
			"pent1m_page":   return {2'b0, pent1m_page};
			"pent1m_rom":    return {7'b0, pent1m_rom};
			"pent1m_1m_on":  return {7'b0, pent1m_1m_on};
			"pent1m_ram0_0": return {7'b0, pent1m_ram0_0};
			"romrw_en":      return {7'b0, romrw_en};
			"set_nmi":       return {7'b0, set_nmi};
			"border":        return {4'b0, border};
			"beeper_wr":     return {7'b0, beeper_wr};
			"clr_nmi":       return {7'b0, clr_nmi};
			"beeper_cnt":    return 8'(beep_cnt - beep_base);
			"clr_nmi_cnt":   return 8'(clr_cnt - clr_base);
			default:         return 8'hxx;      // unknown name never matches
		endcase
	endfunction

	// decode outputs, only valid while the strobe is low
	function automatic bit is_comb(input string sig);
		return (sig == "porthit") || (sig == "external_port") || (sig == "dataout")
			|| (sig == "dout") || (sig == "ay_bc1") || (sig == "ay_bdir");
	endfunction

	task automatic add_step(input int op, input logic [15:0] addr, input logic [7:0] data,
		input logic [7:0] exp, input string sig);
		op_q.push_back(op);
		addr_q.push_back(addr);
		data_q.push_back(data);
		exp_q.push_back(exp);
		sig_q.push_back(sig);
	endtask

	// one bus cycle, strobe low for 3 clocks then 2 idle clocks
	task automatic run_step(input int op, input logic [15:0] addr, input logic [7:0] data,
		input logic [7:0] exp, input string sig);
		beep_base = beep_cnt;
		clr_base  = clr_cnt;
		if (op == OP_CHK)
		begin
			@(negedge zclk);
			compare(sig, observed(sig), exp);
		end
		else
		begin
			@(posedge zclk);
			a      <= addr;
			din    <= data;
			iorq_n <= 1'b0;
			if (op == OP_WR)
				wr_n <= 1'b0;
			else
				rd_n <= 1'b0;
			wait_clocks(1);
			@(negedge zclk);        // mid cycle, strobe still low
			if (is_comb(sig))
				compare(sig, observed(sig), exp);
			wait_clocks(2);
			iorq_n <= 1'b1;
			wr_n   <= 1'b1;
			rd_n   <= 1'b1;
			wait_clocks(2);
			@(negedge zclk);
			if (!is_comb(sig))
				compare(sig, observed(sig), exp);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus table

	task automatic build_table();
		logic [7:0] d1, d2, d3, d4, d5, d6, d7, d8;
		logic [15:0] fe, f6;
		d1 = 8'($urandom) | 8'h01;     // border differs from reset
		d2 = 8'($urandom);
		d3 = 8'($urandom) & 8'hDF;     // lock bit clear
		d4 = 8'($urandom) | 8'h20;     // lock bit set
		d5 = ~d4;                      // every bit differs from the locked value
		d6 = 8'($urandom) & 8'hFB;     // 1m paging on
		d7 = 8'($urandom) | 8'h04;     // block1m
		d8 = (8'($urandom) | 8'h0A) & 8'hFE;   // romrw + nmi, shadow off
		fe = {8'h00, `PORT_FE};
		f6 = {8'h00, `PORT_F6};

		// reset state
		add_step(OP_CHK, 16'h0000, 8'h00, 8'h00, "p7ffd");
		add_step(OP_CHK, 16'h0000, 8'h00, 8'h00, "peff7");
		add_step(OP_CHK, 16'h0000, 8'h00, 8'h00, "border");
		add_step(OP_CHK, 16'h0000, 8'h00, 8'h00, "romrw_en");
		add_step(OP_CHK, 16'h0000, 8'h00, 8'h00, "set_nmi");
		add_step(OP_CHK, 16'h0000, 8'h00, 8'h00, "beeper_wr");
		add_step(OP_CHK, 16'h0000, 8'h00, 8'h00, "clr_nmi");

		// border and beeper, bright is inverted a3
		add_step(OP_WR, fe, d1, {4'b0, ~fe[3], d1[2:0]}, "border");
		add_step(OP_WR, fe, d1, 8'h01, "beeper_cnt");
		add_step(OP_WR, f6, d2, {4'b0, ~f6[3], d2[2:0]}, "border");
		add_step(OP_WR, f6, d2, 8'h00, "beeper_cnt");
		add_step(OP_RD, fe, 8'h00, {1'b1, tape_v, 1'b0, keys_v}, "dout");
		add_step(OP_RD, fe, 8'h00, 8'h01, "dataout");
		add_step(OP_RD, fe, 8'h00, 8'h01, "porthit");

		// #7FFD paging and the 48k lock
		add_step(OP_WR, 16'h7FFD, d3, d3, "p7ffd");
		add_step(OP_WR, 16'h7FFD, d3, {2'b0, d3[7:5], d3[2:0]}, "pent1m_page");
		add_step(OP_WR, 16'h7FFD, d3, {7'b0, d3[4]}, "pent1m_rom");
		add_step(OP_WR, 16'hEFF7, 8'h04, 8'h00, "peff7");
		add_step(OP_WR, 16'hEFF7, 8'h04, 8'h00, "pent1m_1m_on");
		add_step(OP_WR, 16'h7FFD, d4, {3'b000, d4[4:0]}, "p7ffd");
		add_step(OP_WR, 16'h7FFD, d5, {3'b000, d4[4:0]}, "p7ffd");
		add_step(OP_WR, 16'h7FFD, d5, {2'b0, d4[7:5], d4[2:0]}, "pent1m_page");

		// #EFF7, block1m hides bits 6, 3, 2, 1
		add_step(OP_WR, 16'hEFF7, d6, d6, "peff7");
		add_step(OP_WR, 16'hEFF7, d6, 8'h01, "pent1m_1m_on");
		add_step(OP_WR, 16'hEFF7, d6, {7'b0, d6[3]}, "pent1m_ram0_0");
		add_step(OP_WR, 16'hEFF7, d7, d7 & 8'hB1, "peff7");
		add_step(OP_WR, 16'hEFF7, d7, {7'b0, d7[3]}, "pent1m_ram0_0");
		add_step(OP_WR, 16'hEFF7, 8'h00, 8'h01, "pent1m_1m_on");

		// kempston ports, then #BF config and shadow mode
		add_step(OP_RD, {8'h00, `PORT_KJOY}, 8'h00, {3'b000, kj_v}, "dout");
		add_step(OP_RD, {8'h00, `PORT_KMOUSE}, 8'h00, mus_v, "dout");
		add_step(OP_WR, {8'h00, `PORT_CFG}, d8, {7'b0, d8[1]}, "romrw_en");
		add_step(OP_WR, {8'h00, `PORT_CFG}, d8, {7'b0, d8[3]}, "set_nmi");
		add_step(OP_RD, {8'h00, `PORT_CFG}, 8'h00, d8 & 8'h0B, "dout");
		add_step(OP_WR, {8'h00, `PORT_CFG}, 8'h01, 8'h00, "romrw_en");
		add_step(OP_RD, {8'h00, `PORT_KJOY}, 8'h00, 8'h00, "porthit");
		add_step(OP_RD, {8'h00, `PORT_KJOY}, 8'h00, 8'hFF, "dout");
		add_step(OP_WR, 16'hEFF7, 8'h08, 8'h00, "peff7");     // shadow blocks it
		add_step(OP_WR, {8'h00, `PORT_CFG}, 8'h08, 8'h01, "set_nmi");
		add_step(OP_WR, {8'h00, `PORT_NMICLR}, d1, 8'h01, "clr_nmi_cnt");

		// ay select, #FFFD and #BFFD
		add_step(OP_WR, 16'hFFFD, d2, 8'h01, "ay_bc1");
		add_step(OP_WR, 16'hFFFD, d2, 8'h01, "ay_bdir");
		add_step(OP_WR, 16'hBFFD, d2, 8'h01, "ay_bdir");
		add_step(OP_WR, 16'hBFFD, d2, 8'h00, "ay_bc1");
		add_step(OP_RD, 16'hFFFD, 8'h00, 8'h01, "ay_bc1");
		add_step(OP_RD, 16'hFFFD, 8'h00, 8'h01, "external_port");
		add_step(OP_RD, 16'hFFFD, 8'h00, 8'h00, "dataout");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence

	initial
	begin
		int i;
		void'($urandom(32'h47d3c521));
		keys_v = 5'($urandom);
		kj_v   = 5'($urandom);
		mus_v  = 8'($urandom);
		tape_v = 1'($urandom);

		rst_n     <= 1'b0;
		iorq_n    <= 1'b1;
		rd_n      <= 1'b1;
		wr_n      <= 1'b1;
		a         <= 16'h0000;
		din       <= 8'h00;
		dos       <= 1'b0;          // trdos off for the whole run
		keys_in   <= keys_v;
		kj_in     <= kj_v;
		mus_in    <= mus_v;
		tape_read <= tape_v;

		build_table();
		wait_clocks(10);
		rst_n <= 1'b1;
		wait_clocks(1);

		for (i = 0; i < op_q.size(); i++)
		begin
			run_step(op_q[i], addr_q[i], data_q[i], exp_q[i], sig_q[i]);
		end

		$display("All tests passed");
		$finish;
	end

	// watchdog
	initial
	begin
		int n;
		for (n = 0; n < TIMEOUT_CYCLES; n++)
		begin
			@(posedge zclk);
		end
		$display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("Some tests failed");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+rtl
rtl/zports_pkg.sv
rtl/zbus_if.sv
rtl/io_strobe.sv
rtl/port_decode.sv
rtl/mem_paging.sv
rtl/sys_config.sv
rtl/zports_top.sv
verification/zports_tb.sv

//--- run.sh
#!/bin/sh
# compile the z80 port block testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
	-f src.f --top-module zports_tb -Mdir "$BUILD_DIR" -o zports_sim; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/zports_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "All tests passed" "$LOG"; then
	echo "result: PASS"
	exit 0
else
	echo "result: FAIL"
	exit 1
fi
